/* bench/npu_tb.sv */
`timescale 1ns/10ps

module npu_tb;

    localparam int N           = 4;
    localparam int IW          = $clog2(N);
    localparam int WORDS       = N * N / 2;
    localparam int NUM_TESTS   = 5;
    localparam int FINISH_WAIT = 2 * N + 10;
    localparam int WATCHDOG_NS = NUM_TESTS * (N * N + 4 * N + 20) * 40 * 2;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    npu_pkg::stream_beat_t i_map_beat;
    npu_pkg::stream_beat_t i_weight_beat;
    logic                  i_rd_sop;
    logic [IW-1:0]         i_rd_col;
    logic                  o_save_finish;
    npu_pkg::rd_beat_t     o_rd_beat;

    logic [15:0] mat_a [N][N];
    logic [15:0] mat_b [N][N];
    logic [15:0] model_c [N][N];
    logic [15:0] old_c [N][N];
    logic [15:0] lfsr_state = 16'd47;

    int cyc = 0;
    int last_eop_edge = 0;
    int finish_seen = 0;
    int test_errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    npu_top #(.N(N)) dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_map_beat    (i_map_beat),
        .i_weight_beat (i_weight_beat),
        .i_rd_sop      (i_rd_sop),
        .i_rd_col      (i_rd_col),
        .o_save_finish (o_save_finish),
        .o_rd_beat     (o_rd_beat)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    // Edge k leaves cyc at k+1, so at a negedge a beat is accepted at edge cyc
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if ((i_map_beat.vld && i_map_beat.eop) ||
                (i_weight_beat.vld && i_weight_beat.eop)) begin
                last_eop_edge = cyc;
            end
            if (o_save_finish) begin
                finish_seen++;
                check_value("o_save_finish latency", 32'(cyc - 1 - last_eop_edge), 32'(N + 3));
            end
        end
    end

    a_finish_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_save_finish |=> !o_save_finish
    ) else begin
        $display("** Error at %0d ns: o_save_finish expected 0x0, got 0x1", $time);
        test_errors++;
    end

    a_eop_needs_vld: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rd_beat.eop |-> o_rd_beat.vld
    ) else begin
        $display("Read beat carried eop without vld at %0d ns", $time);
        test_errors++;
    end

    a_read_length: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_rd_beat.vld) |-> o_rd_beat.vld [*N] ##1 !o_rd_beat.vld
    ) else begin
        $display("Read-out at %0d ns did not last exactly %0d cycles", $time, N);
        test_errors++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic draw_bits(input int count, output logic [15:0] v);
        v = '0;
        for (int b = 0; b < count; b++) begin
            v[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Fresh A and B, then C modulo 2^16
    task automatic new_operands();
        logic [15:0] acc;
        logic [31:0] prod;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                draw_bits(16, mat_a[i][j]);
                draw_bits(16, mat_b[i][j]);
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = 0; k < N; k++) begin
                    prod = mat_a[i][k] * mat_b[k][j];
                    acc  = acc + prod[15:0];
                end
                model_c[i][j] = acc;
            end
        end
    endtask

    function automatic npu_pkg::stream_beat_t make_beat(input bit use_weight, input int w);
        npu_pkg::stream_beat_t beat;
        int row;
        int col;
        row      = w / (N / 2);
        col      = 2 * (w % (N / 2));
        beat.sop = (w == 0);
        beat.eop = (w == WORDS - 1);
        beat.vld = 1'b1;
        if (use_weight) begin
            beat.data = {mat_b[row][col + 1], mat_b[row][col]};
        end else begin
            beat.data = {mat_a[row][col + 1], mat_a[row][col]};
        end
        return beat;
    endfunction

    task automatic send_stream(input bit use_weight);
        for (int w = 0; w < WORDS; w++) begin
            @(posedge i_clk);
            if (use_weight) begin
                i_weight_beat <= make_beat(1'b1, w);
                i_map_beat    <= '0;
            end else begin
                i_map_beat    <= make_beat(1'b0, w);
                i_weight_beat <= '0;
            end
        end
    endtask

    // 0 map first, 1 weight first, else interleaved with random gaps
    task automatic load_matrices(input int mode);
        int          wa;
        int          wb;
        logic [15:0] go;
        wa = 0;
        wb = 0;
        if (mode == 0) begin
            send_stream(1'b0);
            send_stream(1'b1);
        end else if (mode == 1) begin
            send_stream(1'b1);
            send_stream(1'b0);
        end else begin
            while (wa < WORDS || wb < WORDS) begin
                @(posedge i_clk);
                draw_bits(1, go);
                if (wa < WORDS && go[0]) begin
                    i_map_beat <= make_beat(1'b0, wa);
                    wa++;
                end else begin
                    i_map_beat <= '0;
                end
                draw_bits(1, go);
                if (wb < WORDS && go[0]) begin
                    i_weight_beat <= make_beat(1'b1, wb);
                    wb++;
                end else begin
                    i_weight_beat <= '0;
                end
            end
        end
        @(posedge i_clk);
        i_map_beat    <= '0;
        i_weight_beat <= '0;
    endtask

    task automatic wait_finish(input int base);
        int waited;
        waited = 0;
        while (finish_seen == base && waited < FINISH_WAIT) begin
            @(posedge i_clk);
            waited++;
        end
        if (finish_seen == base) begin
            $display("Timed out after %0d cycles waiting for o_save_finish", FINISH_WAIT);
            test_errors++;
        end
        repeat (N) @(posedge i_clk);
        check_value("o_save_finish pulse count", 32'(finish_seen - base), 32'd1);
    endtask

    task automatic read_column(input int col, input bit use_old);
        logic [15:0] exp;
        @(posedge i_clk);
        i_rd_sop <= 1'b1;
        i_rd_col <= IW'(col);
        @(negedge i_clk);
        check_value("o_rd_beat.vld", 32'(o_rd_beat.vld), 32'd0);
        @(posedge i_clk);
        i_rd_sop <= 1'b0;
        for (int r = 0; r < N; r++) begin
            @(negedge i_clk);
            exp = use_old ? old_c[r][col] : model_c[r][col];
            check_value("o_rd_beat.vld", 32'(o_rd_beat.vld), 32'd1);
            check_value("o_rd_beat.eop", 32'(o_rd_beat.eop), 32'(r == N - 1));
            check_value("o_rd_beat.data", 32'(o_rd_beat.data), 32'(exp));
        end
        @(negedge i_clk);
        check_value("o_rd_beat.vld", 32'(o_rd_beat.vld), 32'd0);
    endtask

    task automatic read_all();
        for (int c = 0; c < N; c++) begin
            read_column(c, 1'b0);
        end
    endtask

    task automatic run_product(input int mode);
        int base;
        new_operands();
        base = finish_seen;
        load_matrices(mode);
        wait_finish(base);
    endtask

    task automatic end_test(input int num, input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %0d %s: pass", num, name);
        end else begin
            fail_count++;
            $display("Test %0d %s: fail with %0d errors", num, name, test_errors);
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int base;
        i_rst_n       = 1'b0;
        i_map_beat    = '0;
        i_weight_beat = '0;
        i_rd_sop      = 1'b0;
        i_rd_col      = '0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;

        repeat (2 * N) begin
            @(negedge i_clk);
            check_value("o_save_finish", 32'(o_save_finish), 32'd0);
            check_value("o_rd_beat.vld", 32'(o_rd_beat.vld), 32'd0);
        end
        end_test(1, "idle after reset");

        run_product(0);
        end_test(2, "finish timing");

        read_all();
        end_test(3, "column read-out");

        // Weight first, then both streams interleaved
        run_product(1);
        read_all();
        run_product(2);
        read_all();
        end_test(4, "load order");

        old_c = model_c;
        new_operands();
        base = finish_seen;
        fork
            load_matrices(0);
            begin
                // Read issued with the last weight beat so its rows overlap the clear
                repeat (2 * WORDS - 1) @(posedge i_clk);
                read_column(2, 1'b1);
            end
        join
        wait_finish(base);
        read_all();
        end_test(5, "second run and overlapped read");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the NPU tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir
EXE=npu_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module npu_tb -f sources.f \
    --Mdir "$MDIR" -o "$EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$MDIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

/* sources.f */
src/npu_pkg.sv
src/operand_loader.sv
src/npu_controller.sv
src/pe_array.sv
src/result_cache.sv
src/npu_top.sv
bench/npu_tb.sv

/* src/npu_controller.sv */
`timescale 1ns/10ps

module npu_controller #(
    parameter int N = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_map_loaded,
    input  logic                 i_weight_loaded,
    output logic                 o_consume,
    output logic                 o_clear,
    output logic                 o_acc_en,
    output logic [$clog2(N)-1:0] o_step,
    output logic                 o_save,
    output logic                 o_save_finish
);

    localparam int IW = $clog2(N);

    npu_pkg::npu_state_e state;
    npu_pkg::npu_state_e state_nxt;
    logic [IW-1:0]       step_cnt;
    logic                both_loaded;

    assign both_loaded = i_map_loaded && i_weight_loaded;

    always_comb begin
        state_nxt = state;
        case (state)
            npu_pkg::ST_IDLE: begin
                if (both_loaded) begin
                    state_nxt = npu_pkg::ST_CLEAR;
                end
            end
            npu_pkg::ST_CLEAR: state_nxt = npu_pkg::ST_CALC;
            npu_pkg::ST_CALC: begin
                if (step_cnt == IW'(N - 1)) begin
                    state_nxt = npu_pkg::ST_SAVE;
                end
            end
            default: state_nxt = npu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state         <= npu_pkg::ST_IDLE;
            step_cnt      <= '0;
            o_save_finish <= 1'b0;
        end else begin
            state         <= state_nxt;
            // Finish follows the save edge by one cycle
            o_save_finish <= (state == npu_pkg::ST_SAVE);
            if (state == npu_pkg::ST_CALC) begin
                step_cnt <= step_cnt + 1'b1;
            end else begin
                step_cnt <= '0;
            end
        end
    end

    assign o_consume = (state == npu_pkg::ST_IDLE) && both_loaded;
    assign o_clear   = (state == npu_pkg::ST_CLEAR);
    assign o_acc_en  = (state == npu_pkg::ST_CALC);
    assign o_step    = step_cnt;
    assign o_save    = (state == npu_pkg::ST_SAVE);

    // A step follows the clear or an earlier step that was not the last
    a_acc_in_calc: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_acc_en |-> $past(o_clear) || ($past(o_acc_en) && $past(o_step) != IW'(N - 1))
    ) else $error("npu_controller: accumulate outside ST_CALC");

    // Clear, N steps, save, then finish with no gaps
    a_run_shape: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_clear |=> o_acc_en [*N] ##1 o_save ##1 o_save_finish
    ) else $error("npu_controller: run sequence broken");

endmodule

/* src/npu_pkg.sv */
package npu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////////////

    // One matrix element, also the accumulator width
    localparam int ELEM_W = 16;

    // Write stream word holds two elements
    localparam int WORD_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Stream and read beats
    ////////////////////////////////////////////////////////////////////////////

    // Write stream beat, low element in data[15:0]
    typedef struct packed {
        logic              sop;
        logic              eop;
        logic              vld;
        logic [WORD_W-1:0] data;
    } stream_beat_t;

    // One row of a column read-out
    typedef struct packed {
        logic              vld;
        logic              eop;
        logic [ELEM_W-1:0] data;
    } rd_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_CALC,
        ST_SAVE
    } npu_state_e;

endpackage

/* src/npu_top.sv */
`timescale 1ns/10ps

module npu_top #(
    parameter int N = 4
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  npu_pkg::stream_beat_t i_map_beat,
    input  npu_pkg::stream_beat_t i_weight_beat,
    input  logic                  i_rd_sop,
    input  logic [$clog2(N)-1:0]  i_rd_col,
    output logic                  o_save_finish,
    output npu_pkg::rd_beat_t     o_rd_beat
);

    logic                                      map_loaded;
    logic                                      weight_loaded;
    logic                                      consume;
    logic                                      clear;
    logic                                      acc_en;
    logic [$clog2(N)-1:0]                      step;
    logic                                      save;
    logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] map_matrix;
    logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] weight_matrix;
    logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] acc;

    ////////////////////////////////////////////////////////////////////////////
    // Operand loaders
    ////////////////////////////////////////////////////////////////////////////

    operand_loader #(.N(N)) u_map_loader (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_beat    (i_map_beat),
        .i_consume (consume),
        .o_loaded  (map_loaded),
        .o_matrix  (map_matrix)
    );

    operand_loader #(.N(N)) u_weight_loader (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_beat    (i_weight_beat),
        .i_consume (consume),
        .o_loaded  (weight_loaded),
        .o_matrix  (weight_matrix)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing, compute and results
    ////////////////////////////////////////////////////////////////////////////

    npu_controller #(.N(N)) u_controller (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_map_loaded    (map_loaded),
        .i_weight_loaded (weight_loaded),
        .o_consume       (consume),
        .o_clear         (clear),
        .o_acc_en        (acc_en),
        .o_step          (step),
        .o_save          (save),
        .o_save_finish   (o_save_finish)
    );

    pe_array #(.N(N)) u_pe_array (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_clear  (clear),
        .i_acc_en (acc_en),
        .i_step   (step),
        .i_map    (map_matrix),
        .i_weight (weight_matrix),
        .o_acc    (acc)
    );

    result_cache #(.N(N)) u_result_cache (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_save    (save),
        .i_acc     (acc),
        .i_rd_sop  (i_rd_sop),
        .i_rd_col  (i_rd_col),
        .o_rd_beat (o_rd_beat)
    );

endmodule

/* src/operand_loader.sv */
`timescale 1ns/10ps

module operand_loader #(
    parameter int N = 4
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst_n,
    input  npu_pkg::stream_beat_t                     i_beat,
    input  logic                                      i_consume,
    output logic                                      o_loaded,
    output logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] o_matrix
);

    localparam int IW    = $clog2(N);
    localparam int HALF  = N / 2;
    localparam int WORDS = N * N / 2;
    localparam int PW    = $clog2(WORDS);

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] word_idx;
    logic [IW-1:0] wr_row;
    logic [IW-1:0] wr_col_lo;
    logic [IW-1:0] wr_col_hi;

    // Start of matrix always lands on word 0
    assign word_idx = i_beat.sop ? '0 : wr_ptr;

    // Both halves of a word sit in the same row since N is even
    always_comb begin
        wr_row    = IW'(word_idx / HALF);
        wr_col_lo = IW'(2 * (word_idx % HALF));
        wr_col_hi = IW'(2 * (word_idx % HALF) + 1);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            o_loaded <= 1'b0;
        end else begin
            if (i_beat.vld) begin
                wr_ptr <= PW'(word_idx + 1'b1);
            end
            if (i_beat.vld && i_beat.eop) begin
                o_loaded <= 1'b1;
            end else if (i_consume) begin
                o_loaded <= 1'b0;
            end
        end
    end

    // Operand storage
    always_ff @(posedge i_clk) begin
        if (i_beat.vld) begin
            o_matrix[wr_row][wr_col_lo] <= i_beat.data[npu_pkg::ELEM_W-1:0];
            o_matrix[wr_row][wr_col_hi] <= i_beat.data[npu_pkg::WORD_W-1:npu_pkg::ELEM_W];
        end
    end

    // A matrix must be consumed by the controller before the next one completes
    a_no_overwrite: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_beat.vld && i_beat.eop) |-> !o_loaded
    ) else $error("operand_loader: eop while previous matrix still pending");

endmodule

/* src/pe_array.sv */
`timescale 1ns/10ps

module pe_array #(
    parameter int N = 4
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst_n,
    input  logic                                      i_clear,
    input  logic                                      i_acc_en,
    input  logic [$clog2(N)-1:0]                      i_step,
    input  logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] i_map,
    input  logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] i_weight,
    output logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] o_acc
);

    localparam int EW = npu_pkg::ELEM_W;

    // Column k of A runs along the rows, row k of B runs down the columns
    logic [N-1:0][EW-1:0] row_op;
    logic [N-1:0][EW-1:0] col_op;

    genvar gi;
    genvar gj;

    ////////////////////////////////////////////////////////////////////////////
    // Operand broadcast for the current step
    ////////////////////////////////////////////////////////////////////////////

    generate
        for (gi = 0; gi < N; gi++) begin : g_sel
            assign row_op[gi] = i_map[gi][i_step];
            assign col_op[gi] = i_weight[i_step][gi];
        end
    endgenerate

    ////////////////////////////////////////////////////////////////////////////
    // MAC grid
    ////////////////////////////////////////////////////////////////////////////

    generate
        for (gi = 0; gi < N; gi++) begin : g_row
            for (gj = 0; gj < N; gj++) begin : g_col
                logic [EW-1:0] prod;

                // Product kept to the low half, sums wrap mod 2^16
                assign prod = row_op[gi] * col_op[gj];

                always_ff @(posedge i_clk) begin
                    if (!i_rst_n) begin
                        o_acc[gi][gj] <= '0;
                    end else if (i_clear) begin
                        o_acc[gi][gj] <= '0;
                    end else if (i_acc_en) begin
                        o_acc[gi][gj] <= o_acc[gi][gj] + prod;
                    end
                end
            end
        end
    endgenerate

    // A step must never coincide with the clear of the same run
    a_clear_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_clear |-> !i_acc_en ##1 !i_clear
    ) else $error("pe_array: clear overlaps accumulate");

endmodule

/* src/result_cache.sv */
`timescale 1ns/10ps

module result_cache #(
    parameter int N = 4
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst_n,
    input  logic                                      i_save,
    input  logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] i_acc,
    input  logic                                      i_rd_sop,
    input  logic [$clog2(N)-1:0]                      i_rd_col,
    output npu_pkg::rd_beat_t                         o_rd_beat
);

    localparam int IW = $clog2(N);

    logic [N-1:0][N-1:0][npu_pkg::ELEM_W-1:0] snap;
    logic                                      busy;
    logic [IW-1:0]                             rd_row;
    logic [IW-1:0]                             rd_col;
    logic                                      last_row;

    assign last_row = (rd_row == IW'(N - 1));

    // Snapshot of C, held until the next save
    always_ff @(posedge i_clk) begin
        if (i_save) begin
            snap <= i_acc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column read-out
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            rd_row <= '0;
            rd_col <= '0;
        end else if (!busy) begin
            if (i_rd_sop) begin
                busy   <= 1'b1;
                rd_row <= '0;
                rd_col <= i_rd_col;
            end
        end else begin
            rd_row <= rd_row + 1'b1;
            if (last_row) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        o_rd_beat.vld  = busy;
        o_rd_beat.eop  = busy && last_row;
        o_rd_beat.data = snap[rd_row][rd_col];
    end

    // Requests during a read-out are dropped
    a_no_sop_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_rd_sop |-> !busy
    ) else $error("result_cache: read request during read-out ignored");

endmodule
